/* flist.f */
hw/rv32i_types_pkg.sv
hw/ooo_types_pkg.sv
hw/ooo_ifs.sv
hw/fetch.sv
hw/cacheline_adapter.sv
hw/inst_queue.sv
hw/rename.sv
hw/rob.sv
hw/cpu_frontend.sv
tb/tb_top.sv

/* hw/cacheline_adapter.sv */
`timescale 1ns/10ps

module cacheline_adapter (
    input  logic                 clk,
    input  logic                 rst,
    line_fill_if.adapter         fill,
    output logic [31:0]          bmem_addr_o,
    output logic                 bmem_read_o,
    input  ooo_types_pkg::beat_t bmem_rdata_i,
    input  logic                 bmem_rvalid_i
);
    import ooo_types_pkg::*;

    logic [1:0] beat_cnt;
    line_t      line_q;

    // the request strobe goes straight out as the read
    assign bmem_read_o = fill.req;
    assign bmem_addr_o = fill.addr;
    assign fill.line   = line_q;

    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            // new beat enters at the top, beat 0 ends at the bottom
            line_q <= {bmem_rdata_i, line_q[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt  <= 2'd0;
            fill.resp <= 1'b0;
        end else begin
            fill.resp <= bmem_rvalid_i && (beat_cnt == 2'd3);    // after fourth beat
            if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

endmodule

/* hw/cpu_frontend.sv */
`timescale 1ns/10ps

module cpu_frontend #(
    parameter logic [31:0] RESET_PC  = 32'h1eceb000,
    parameter int          IQ_DEPTH  = 16,
    parameter int          ROB_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,

    output logic [31:0]                   bmem_addr_o,
    output logic                          bmem_read_o,
    input  ooo_types_pkg::beat_t          bmem_rdata_i,
    input  logic                          bmem_rvalid_i,

    output logic                          disp_valid_o,
    output ooo_types_pkg::arch_reg_t      disp_rd_o,
    output ooo_types_pkg::phys_reg_t      disp_pd_o,
    output ooo_types_pkg::phys_reg_t      disp_ps1_o,
    output ooo_types_pkg::phys_reg_t      disp_ps2_o,
    output logic                          disp_we_o,
    output logic [$clog2(ROB_DEPTH)-1:0]  disp_rob_idx_o,

    input  logic                          cmpl_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]  cmpl_rob_idx_i,

    output logic                          ret_valid_o,
    output logic                          ret_we_o,
    output ooo_types_pkg::arch_reg_t      ret_rd_o,
    output ooo_types_pkg::phys_reg_t      ret_pd_o,
    output ooo_types_pkg::phys_reg_t      ret_old_pd_o
);
    import ooo_types_pkg::*;

    logic        iq_enq, iq_full, iq_empty, iq_deq;
    logic [31:0] iq_wdata, iq_rdata;
    logic        rob_full;
    logic [$clog2(ROB_DEPTH)-1:0] rob_idx;
    logic        alloc, alloc_we;
    arch_reg_t   alloc_rd;
    phys_reg_t   alloc_pd, alloc_old_pd;

    line_fill_if fill_if ();
    retire_if    ret_if ();

    fetch #(.RESET_PC(RESET_PC)) fetch_i (
        .clk(clk), .rst(rst), .fill(fill_if.fetch),
        .iq_full_i(iq_full), .iq_enq_o(iq_enq), .iq_word_o(iq_wdata)
    );

    cacheline_adapter adapter_i (
        .clk(clk), .rst(rst), .fill(fill_if.adapter),
        .bmem_addr_o(bmem_addr_o), .bmem_read_o(bmem_read_o),
        .bmem_rdata_i(bmem_rdata_i), .bmem_rvalid_i(bmem_rvalid_i)
    );

    inst_queue #(.DEPTH(IQ_DEPTH), .WIDTH(32)) iq_i (
        .clk(clk), .rst(rst), .enq_i(iq_enq), .wdata_i(iq_wdata), .full_o(iq_full),
        .deq_i(iq_deq), .rdata_o(iq_rdata), .empty_o(iq_empty)
    );

    rename #(.ROB_DEPTH(ROB_DEPTH)) rename_i (
        .clk(clk), .rst(rst), .inst_i(iq_rdata), .iq_empty_i(iq_empty), .iq_deq_o(iq_deq),
        .rob_full_i(rob_full), .rob_idx_i(rob_idx),
        .alloc_o(alloc), .alloc_rd_o(alloc_rd), .alloc_pd_o(alloc_pd),
        .alloc_old_pd_o(alloc_old_pd), .alloc_we_o(alloc_we),
        .disp_ps1_o(disp_ps1_o), .disp_ps2_o(disp_ps2_o),
        .disp_rob_idx_o(disp_rob_idx_o), .ret(ret_if.rename)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
        .clk(clk), .rst(rst), .alloc_i(alloc), .alloc_rd_i(alloc_rd), .alloc_pd_i(alloc_pd),
        .alloc_old_pd_i(alloc_old_pd), .alloc_we_i(alloc_we),
        .full_o(rob_full), .idx_o(rob_idx),
        .cmpl_valid_i(cmpl_valid_i), .cmpl_idx_i(cmpl_rob_idx_i), .ret(ret_if.rob)
    );

    // dispatch port mirrors the allocation into the rob
    assign disp_valid_o = alloc;
    assign disp_rd_o    = alloc_rd;
    assign disp_pd_o    = alloc_pd;
    assign disp_we_o    = alloc_we;

    assign ret_valid_o  = ret_if.valid;
    assign ret_we_o     = ret_if.we;
    assign ret_rd_o     = ret_if.rd;
    assign ret_pd_o     = ret_if.pd;
    assign ret_old_pd_o = ret_if.old_pd;

endmodule

/* hw/fetch.sv */
`timescale 1ns/10ps

module fetch #(
    parameter logic [31:0] RESET_PC = 32'h1eceb000
) (
    input  logic              clk,
    input  logic              rst,
    line_fill_if.fetch        fill,
    input  logic              iq_full_i,
    output logic              iq_enq_o,
    output logic [31:0]       iq_word_o
);
    import ooo_types_pkg::*;

    logic [31:0] pc;
    line_t       line_buf;
    logic [26:0] line_tag;    // pc bits 31:5 of the buffered line
    logic        line_valid;
    logic        waiting;     // request out, no resp yet
    logic        hit;

    assign hit       = line_valid && (line_tag == pc[31:5]);
    assign iq_enq_o  = hit && !iq_full_i;
    assign iq_word_o = line_buf[32*pc[4:2] +: 32];    // word at pc within the line

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            line_valid <= 1'b0;
            waiting    <= 1'b0;
            fill.req   <= 1'b0;
        end else begin
            fill.req <= 1'b0;

            if (iq_enq_o) begin
                pc <= pc + 32'd4;
                // last word of the line, drop it
                if (pc[4:2] == 3'b111) begin
                    line_valid <= 1'b0;
                end
            end

            // miss with nothing pending, ask once
            if (!hit && !waiting) begin
                fill.req  <= 1'b1;
                fill.addr <= {pc[31:5], 5'b0};
                waiting   <= 1'b1;
            end

            if (fill.resp) begin
                line_buf   <= fill.line;
                line_tag   <= fill.addr[31:5];
                line_valid <= 1'b1;
                waiting    <= 1'b0;
            end
        end
    end

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/10ps

module inst_queue #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enq_i,
    input  logic [WIDTH-1:0] wdata_i,
    output logic             full_o,
    input  logic             deq_i,
    output logic [WIDTH-1:0] rdata_o,
    output logic             empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W:0]   wptr;    // top bit is the wrap bit
    logic [PTR_W:0]   rptr;
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (wptr == rptr);
    assign full_o  = (wptr[PTR_W] != rptr[PTR_W]) &&
                     (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);

    assign do_wr   = enq_i && !full_o;
    assign do_rd   = deq_i && !empty_o;
    assign rdata_o = mem[rptr[PTR_W-1:0]];    // head word

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr[PTR_W-1:0]] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

endmodule

/* hw/ooo_ifs.sv */
`timescale 1ns/10ps

// line request from fetch and the filled line coming back
interface line_fill_if;
    import ooo_types_pkg::*;

    logic  [31:0] addr;    // line aligned
    logic         req;     // single cycle strobe
    line_t        line;
    logic         resp;    // single cycle, line valid

    modport fetch (output addr, output req, input line, input resp);
    modport adapter (input addr, input req, output line, output resp);
endinterface

// one retirement per cycle from the ROB
interface retire_if;
    import ooo_types_pkg::*;

    logic      valid;
    logic      we;
    arch_reg_t rd;
    phys_reg_t pd;
    phys_reg_t old_pd;    // goes back to the free list

    modport rob (output valid, output we, output rd, output pd, output old_pd);
    // rename only needs what recycles a register
    modport rename (input valid, input we, input old_pd);
endinterface

/* hw/ooo_types_pkg.sv */
package ooo_types_pkg;

    localparam int N_ARCH_REGS = 32;
    localparam int N_PHYS_REGS = 64;

    // architectural register index, x0 to x31
    typedef logic [$clog2(N_ARCH_REGS)-1:0] arch_reg_t;

    // physical register tag, p0 to p63
    typedef logic [$clog2(N_PHYS_REGS)-1:0] phys_reg_t;

    // one cache line, 8 instruction words
    typedef logic [255:0] line_t;

    // one memory beat
    typedef logic [63:0] beat_t;

endpackage

/* hw/rename.sv */
`timescale 1ns/10ps

module rename #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  rv32i_types_pkg::inst_u        inst_i,
    input  logic                          iq_empty_i,
    output logic                          iq_deq_o,
    input  logic                          rob_full_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]  rob_idx_i,
    output logic                          alloc_o,
    output ooo_types_pkg::arch_reg_t      alloc_rd_o,
    output ooo_types_pkg::phys_reg_t      alloc_pd_o,
    output ooo_types_pkg::phys_reg_t      alloc_old_pd_o,
    output logic                          alloc_we_o,
    output ooo_types_pkg::phys_reg_t      disp_ps1_o,
    output ooo_types_pkg::phys_reg_t      disp_ps2_o,
    output logic [$clog2(ROB_DEPTH)-1:0]  disp_rob_idx_o,
    retire_if.rename                      ret
);
    import rv32i_types_pkg::*;
    import ooo_types_pkg::*;

    localparam int FL_DEPTH = N_PHYS_REGS - N_ARCH_REGS;
    localparam int FL_W     = $clog2(FL_DEPTH);

    phys_reg_t       rat [N_ARCH_REGS];
    phys_reg_t       fl_mem [FL_DEPTH];
    logic [FL_W-1:0] fl_head;
    logic [FL_W-1:0] fl_tail;
    logic [FL_W:0]   fl_count;
    logic            fl_push;
    logic            fl_pop;
    logic            is_sb;
    logic            writes;
    logic            dispatch;
    arch_reg_t       rd;

    // store and branch carry immediate bits where rd would be
    assign is_sb = inst_i.s.opcode inside {op_br, op_store};
    assign rd    = is_sb ? '0 : inst_i.r.rd;

    always_comb begin
        case (inst_i.r.opcode)
            op_lui, op_auipc, op_jal, op_jalr: writes = 1'b1;
            op_load, op_imm, op_reg:           writes = 1'b1;
            op_br, op_store:                   writes = 1'b0;
            default:                           writes = 1'b0;
        endcase
    end

    assign alloc_we_o = writes && (rd != '0);    // x0 never renamed

    // stall on rob full, or no free register when one is needed
    assign dispatch = !iq_empty_i && !rob_full_i && (!alloc_we_o || fl_count != '0);
    assign iq_deq_o = dispatch;
    assign alloc_o  = dispatch;

    assign alloc_rd_o     = rd;
    assign alloc_pd_o     = alloc_we_o ? fl_mem[fl_head] : '0;
    assign alloc_old_pd_o = rat[rd];
    assign disp_ps1_o     = rat[inst_i.r.rs1];    // mapping before own update
    assign disp_ps2_o     = rat[inst_i.r.rs2];
    assign disp_rob_idx_o = rob_idx_i;

    assign fl_pop  = dispatch && alloc_we_o;
    assign fl_push = ret.valid && ret.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N_ARCH_REGS; i++) begin
                rat[i] <= phys_reg_t'(i);    // identity map
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= phys_reg_t'(N_ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FL_W+1)'(FL_DEPTH);
        end else begin
            if (fl_pop) begin
                rat[rd] <= fl_mem[fl_head];
                fl_head <= fl_head + 1'b1;
            end
            if (fl_push) begin
                fl_mem[fl_tail] <= ret.old_pd;    // freed at retirement
                fl_tail         <= fl_tail + 1'b1;
            end
            case ({fl_push, fl_pop})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

endmodule

/* hw/rob.sv */
`timescale 1ns/10ps

module rob #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alloc_i,
    input  ooo_types_pkg::arch_reg_t      alloc_rd_i,
    input  ooo_types_pkg::phys_reg_t      alloc_pd_i,
    input  ooo_types_pkg::phys_reg_t      alloc_old_pd_i,
    input  logic                          alloc_we_i,
    output logic                          full_o,
    output logic [$clog2(ROB_DEPTH)-1:0]  idx_o,
    input  logic                          cmpl_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]  cmpl_idx_i,
    retire_if.rob                         ret
);
    import ooo_types_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    arch_reg_t  ent_rd [ROB_DEPTH];
    phys_reg_t  ent_pd [ROB_DEPTH];
    phys_reg_t  ent_old_pd [ROB_DEPTH];
    logic       ent_we [ROB_DEPTH];
    logic       ent_done [ROB_DEPTH];
    logic [IDX_W:0] head;
    logic [IDX_W:0] tail;
    logic [IDX_W-1:0] hidx;
    logic       retire;

    assign full_o = (head[IDX_W] != tail[IDX_W]) && (head[IDX_W-1:0] == tail[IDX_W-1:0]);
    assign idx_o  = tail[IDX_W-1:0];
    assign hidx   = head[IDX_W-1:0];
    assign retire = (head != tail) && ent_done[hidx];    // oldest entry finished

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            ent_rd[idx_o]     <= alloc_rd_i;
            ent_pd[idx_o]     <= alloc_pd_i;
            ent_old_pd[idx_o] <= alloc_old_pd_i;
            ent_we[idx_o]     <= alloc_we_i;
            ent_done[idx_o]   <= 1'b0;
        end
        if (cmpl_valid_i) begin
            ent_done[cmpl_idx_i] <= 1'b1;
        end
        ret.we     <= ent_we[hidx];
        ret.rd     <= ent_rd[hidx];
        ret.pd     <= ent_pd[hidx];
        ret.old_pd <= ent_old_pd[hidx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            ret.valid <= 1'b0;
        end else begin
            ret.valid <= retire;
            if (alloc_i) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
        end
    end

endmodule

/* hw/rv32i_types_pkg.sv */
package rv32i_types_pkg;

    // base opcodes of the nine RV32I instruction groups
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    // R layout, rd sits in bits 11:7
    typedef struct packed {
        logic [6:0]    funct7;
        logic [4:0]    rs2;
        logic [4:0]    rs1;
        logic [2:0]    funct3;
        logic [4:0]    rd;
        rv32i_opcode_t opcode;
    } r_type_t;

    // S and B layout, bits 11:7 hold low immediate bits
    typedef struct packed {
        logic [6:0]    imm_hi;
        logic [4:0]    rs2;
        logic [4:0]    rs1;
        logic [2:0]    funct3;
        logic [4:0]    imm_lo;
        rv32i_opcode_t opcode;
    } s_type_t;

    typedef union packed {
        r_type_t r;
        s_type_t s;
    } inst_u;

endpackage

/* tb/tb_top.sv */
`timescale 1ns/10ps

module tb_top;
    import rv32i_types_pkg::*;
    import ooo_types_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h1eceb000;
    localparam int ROB_DEPTH = 64;    // deeper than the free list so it can run dry
    localparam int IDX_W     = $clog2(ROB_DEPTH);
    localparam int N_INSTR   = 400;
    localparam int MEM_WORDS = 512;    // room for fetch running ahead of retirement
    localparam int TIMEOUT   = 16 + 40 * N_INSTR;

    typedef logic [IDX_W-1:0] rob_idx_t;

    // one expected retirement, in program order
    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t pd;
        phys_reg_t old_pd;
        logic      we;
        rob_idx_t  idx;
    } ret_rec_t;

    logic        clk;
    logic        rst;
    logic [31:0] bmem_addr_o;
    logic        bmem_read_o;
    beat_t       bmem_rdata_i;
    logic        bmem_rvalid_i;
    logic        disp_valid_o;
    arch_reg_t   disp_rd_o;
    phys_reg_t   disp_pd_o;
    phys_reg_t   disp_ps1_o;
    phys_reg_t   disp_ps2_o;
    logic        disp_we_o;
    rob_idx_t    disp_rob_idx_o;
    logic        cmpl_valid_i;
    rob_idx_t    cmpl_rob_idx_i;
    logic        ret_valid_o;
    logic        ret_we_o;
    arch_reg_t   ret_rd_o;
    phys_reg_t   ret_pd_o;
    phys_reg_t   ret_old_pd_o;

    integer        seed;
    int            cycle;
    int            errors;
    int            dispatched;
    int            retired;
    logic [31:0]   prog [MEM_WORDS];
    rv32i_opcode_t opcodes [9] = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                                   op_load, op_store, op_imm, op_reg};

    // reference model state
    phys_reg_t   rat [N_ARCH_REGS];
    phys_reg_t   free_list [$];
    ret_rec_t    ret_q [$];
    rob_idx_t    pending [$];    // dispatched, not yet completed
    logic        completed [ROB_DEPTH];
    rob_idx_t    exp_idx;
    logic [31:0] exp_line_addr;

    // memory model state
    logic        rd_pending;
    logic [31:0] rd_addr;
    int          rd_beat;
    int          rd_wait;

    cpu_frontend #(
        .RESET_PC(RESET_PC),
        .IQ_DEPTH(16),
        .ROB_DEPTH(ROB_DEPTH)
    ) dut (
        .clk(clk), .rst(rst),
        .bmem_addr_o(bmem_addr_o), .bmem_read_o(bmem_read_o),
        .bmem_rdata_i(bmem_rdata_i), .bmem_rvalid_i(bmem_rvalid_i),
        .disp_valid_o(disp_valid_o), .disp_rd_o(disp_rd_o), .disp_pd_o(disp_pd_o),
        .disp_ps1_o(disp_ps1_o), .disp_ps2_o(disp_ps2_o), .disp_we_o(disp_we_o),
        .disp_rob_idx_o(disp_rob_idx_o),
        .cmpl_valid_i(cmpl_valid_i), .cmpl_rob_idx_i(cmpl_rob_idx_i),
        .ret_valid_o(ret_valid_o), .ret_we_o(ret_we_o), .ret_rd_o(ret_rd_o),
        .ret_pd_o(ret_pd_o), .ret_old_pd_o(ret_old_pd_o)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        errors++;
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_phys(input string name, input phys_reg_t got, input phys_reg_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_arch(input string name, input arch_reg_t got, input arch_reg_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // opcodes whose result goes to rd
    function automatic logic opcode_writes(input logic [6:0] op);
        case (op)
            op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // beat 0 carries the two lowest words of the line
    function automatic beat_t line_beat(input logic [31:0] addr, input int beat);
        int base;
        base = int'((addr - RESET_PC) >> 2) + 2 * beat;
        return {prog[base + 1], prog[base]};
    endfunction

    initial begin
        logic [31:0] w;
        seed   = 55006;
        cycle  = 0;
        errors = 0;
        clk    = 1'b0;
        rst    = 1'b1;
        bmem_rdata_i   = '0;
        bmem_rvalid_i  = 1'b0;
        cmpl_valid_i   = 1'b0;
        cmpl_rob_idx_i = '0;

        for (int i = 0; i < MEM_WORDS; i++) begin
            w = $random(seed);
            if ((i / 64) % 2 == 1) begin
                // no register writes here so the ROB fills before the free list
                w[6:0] = ($unsigned($random(seed)) % 2 == 1) ? op_store : op_br;
            end else begin
                w[6:0] = opcodes[$unsigned($random(seed)) % 9];
            end
            if ($unsigned($random(seed)) % 8 == 0) begin
                w[11:7] = 5'd0;    // some writes to x0
            end
            prog[i] = w;
        end

        for (int i = 0; i < N_ARCH_REGS; i++) begin
            rat[i] = phys_reg_t'(i);
        end
        for (int i = N_ARCH_REGS; i < N_PHYS_REGS; i++) begin
            free_list.push_back(phys_reg_t'(i));
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            completed[i] = 1'b0;
        end
        exp_idx       = '0;
        exp_line_addr = RESET_PC;
        dispatched    = 0;
        retired       = 0;
        rd_pending    = 1'b0;
        rd_beat       = 0;
        rd_wait       = 0;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

    // drive memory beats and completions
    always @(posedge clk) begin
        int k;
        int cmpl_pct;
        cycle = cycle + 1;
        if (cycle >= TIMEOUT) begin
            stop_with_failure($sformatf("run did not finish within %0d cycles", TIMEOUT));
        end

        bmem_rvalid_i <= 1'b0;
        if (!rst && rd_pending) begin
            if (rd_wait > 0) begin
                rd_wait = rd_wait - 1;
            end else begin
                bmem_rvalid_i <= 1'b1;
                bmem_rdata_i  <= line_beat(rd_addr, rd_beat);
                rd_beat = rd_beat + 1;
                rd_wait = $unsigned($random(seed)) % 3;    // gap before next beat
                if (rd_beat == 4) begin
                    rd_pending = 1'b0;
                end
            end
        end

        // slow and fast completion phases, slow ones fill the ROB
        cmpl_pct = ((cycle / 400) % 2 == 1) ? 75 : 12;
        cmpl_valid_i <= 1'b0;
        if (!rst && pending.size() > 0 && ($unsigned($random(seed)) % 100) < cmpl_pct) begin
            k = $unsigned($random(seed)) % pending.size();
            cmpl_valid_i   <= 1'b1;
            cmpl_rob_idx_i <= pending[k];
            completed[pending[k]] = 1'b1;
            pending.delete(k);
        end
    end

    // observe outputs mid cycle and run the reference model
    always @(negedge clk) begin
        logic [31:0] w;
        logic [6:0]  op;
        arch_reg_t   exp_rd;
        logic        exp_we;
        ret_rec_t    rec;
        logic        freed_valid;
        phys_reg_t   freed_pd;

        if (rst) begin
            check_bit("bmem_read_o", bmem_read_o, 1'b0);
            check_bit("disp_valid_o", disp_valid_o, 1'b0);
            check_bit("ret_valid_o", ret_valid_o, 1'b0);
        end else begin
            if (bmem_read_o) begin
                if (rd_pending) begin
                    stop_with_failure("line request issued while another is outstanding");
                end
                check_addr("bmem_addr_o", bmem_addr_o, exp_line_addr);
                if (int'((bmem_addr_o - RESET_PC) >> 2) + 8 > MEM_WORDS) begin
                    stop_with_failure("line request beyond the end of the program memory");
                end
                exp_line_addr = exp_line_addr + 32'd32;
                rd_pending = 1'b1;
                rd_addr    = bmem_addr_o;
                rd_beat    = 0;
                rd_wait    = $unsigned($random(seed)) % 6;
            end

            // retire first, its ROB slot may be reused by this cycle's dispatch
            freed_valid = 1'b0;
            freed_pd    = '0;
            if (ret_valid_o) begin
                if (ret_q.size() == 0) begin
                    stop_with_failure("retirement seen with no instruction in flight");
                end
                rec = ret_q.pop_front();
                if (!completed[rec.idx]) begin
                    stop_with_failure("instruction retired before its completion");
                end
                check_bit("ret_we_o", ret_we_o, rec.we);
                check_arch("ret_rd_o", ret_rd_o, rec.rd);
                check_phys("ret_pd_o", ret_pd_o, rec.pd);
                check_phys("ret_old_pd_o", ret_old_pd_o, rec.old_pd);
                if (rec.we) begin
                    freed_valid = 1'b1;
                    freed_pd    = rec.old_pd;
                end
                retired = retired + 1;
            end

            if (disp_valid_o) begin
                if (dispatched >= MEM_WORDS) begin
                    stop_with_failure("dispatch past the end of the program");
                end
                w      = prog[dispatched];
                op     = w[6:0];
                exp_rd = (op == op_br || op == op_store) ? 5'd0 : w[11:7];
                exp_we = opcode_writes(op) && (exp_rd != 5'd0);

                check_bit("disp_we_o", disp_we_o, exp_we);
                check_arch("disp_rd_o", disp_rd_o, exp_rd);
                check_phys("disp_ps1_o", disp_ps1_o, rat[w[19:15]]);
                check_phys("disp_ps2_o", disp_ps2_o, rat[w[24:20]]);
                check_idx("disp_rob_idx_o", disp_rob_idx_o, exp_idx);

                rec.rd     = exp_rd;
                rec.old_pd = rat[exp_rd];
                rec.we     = exp_we;
                rec.idx    = exp_idx;
                rec.pd     = '0;
                if (exp_we) begin
                    if (free_list.size() == 0) begin
                        stop_with_failure("register write dispatched with the free list empty");
                    end
                    check_phys("disp_pd_o", disp_pd_o, free_list[0]);
                    rec.pd      = free_list.pop_front();
                    rat[exp_rd] = rec.pd;
                end else begin
                    check_phys("disp_pd_o", disp_pd_o, '0);
                end

                ret_q.push_back(rec);
                if (ret_q.size() > ROB_DEPTH) begin
                    stop_with_failure("more instructions in flight than the ROB holds");
                end
                completed[exp_idx] = 1'b0;
                pending.push_back(exp_idx);
                exp_idx    = exp_idx + 1'b1;    // wraps at ROB_DEPTH
                dispatched = dispatched + 1;
            end

            // returned register only visible to later dispatches
            if (freed_valid) begin
                free_list.push_back(freed_pd);
            end

            if (retired == N_INSTR) begin
                if (errors == 0) begin
                    $display("Simulation PASSED");
                    $finish;
                end else begin
                    stop_with_failure("checks failed during the run");
                end
            end
        end
    end

endmodule
